/* src/core_pkg.sv */
package core_pkg;

    localparam int xlen = 64;

    typedef logic [4:0] regnum_t;

    // ==========================================================================
    // Opcodes and SPECIAL function codes.
    // ==========================================================================

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_daddi   = 6'h18;

    localparam logic [5:0] fn_sll    = 6'h00;
    localparam logic [5:0] fn_srl    = 6'h02;
    localparam logic [5:0] fn_add    = 6'h20;
    localparam logic [5:0] fn_sub    = 6'h22;
    localparam logic [5:0] fn_and    = 6'h24;
    localparam logic [5:0] fn_or     = 6'h25;
    localparam logic [5:0] fn_xor    = 6'h26;
    localparam logic [5:0] fn_nor    = 6'h27;
    localparam logic [5:0] fn_slt    = 6'h2a;
    localparam logic [5:0] fn_dadd   = 6'h2c;
    localparam logic [5:0] fn_dsub   = 6'h2e;
    localparam logic [5:0] fn_dsll   = 6'h38;
    localparam logic [5:0] fn_dsrl   = 6'h3a;
    localparam logic [5:0] fn_dsll32 = 6'h3c;
    localparam logic [5:0] fn_dsrl32 = 6'h3e;

    // ==========================================================================
    // Control encodings.
    // ==========================================================================

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor} alu_op_t;

    typedef enum logic [1:0] {from_reg, from_ex, from_mem} forward_t;

    typedef enum logic [1:0] {reg_b, sign_imm, zero_imm} imm_src_t;

    typedef enum logic [1:0] {plus32_none, plus32_left, plus32_right} plus32_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [xlen-1:0] a_data;
        logic [xlen-1:0] b_data;
        regnum_t         w_regnum;
        logic            write_enable;
        alu_op_t         alu_op;
        imm_src_t        imm_src;
        logic            slt;
        logic            cut_alu_out32;
        logic            cut_shifter_out32;
        logic            shift_right;
        plus32_t         shifter_plus32;
        logic            alu_shifter_src;
        logic            lui;
    } id_regs_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] out;
        regnum_t         w_regnum;
        logic            write_enable;
        logic            overflow;
    } ex_regs_t;

endpackage

/* src/stage_if.sv */
`timescale 1ns/100ps

interface stage_if #(
    parameter type payload_t = logic
) (
    input logic flush
);
    payload_t regs;
    logic     valid;
    logic     clear;

    // Nothing live for the next stage, or dropped at the coming edge.
    assign clear = flush | ~valid;

    modport producer (output regs, output valid, input flush);
    modport consumer (input regs, input flush, input clear, input valid);

endinterface

/* src/core_regfile.sv */
`timescale 1ns/100ps

module core_regfile #(
    parameter int num_regs = 32
) (
    input  logic                      clock,
    input  logic                      reset,
    input  core_pkg::regnum_t         read_a_num,
    input  core_pkg::regnum_t         read_b_num,
    output logic [core_pkg::xlen-1:0] read_a_data,
    output logic [core_pkg::xlen-1:0] read_b_data,
    input  logic                      write_enable,
    input  core_pkg::regnum_t         write_num,
    input  logic [core_pkg::xlen-1:0] write_data
);
    import core_pkg::*;

    logic [xlen-1:0] regs [num_regs];
    logic            write_live;

    assign write_live = write_enable && (write_num != '0);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_live) begin
            regs[write_num] <= write_data;
        end
    end

    // Write-through so decode sees a value written at the coming edge.
    function automatic logic [xlen-1:0] read_reg(input regnum_t num,
                                                 input logic [xlen-1:0] stored,
                                                 input logic live,
                                                 input regnum_t wnum,
                                                 input logic [xlen-1:0] wdata);
        if (num == '0) begin
            return '0;
        end
        if (live && (wnum == num)) begin
            return wdata;
        end
        return stored;
    endfunction

    assign read_a_data = read_reg(read_a_num, regs[read_a_num], write_live, write_num,
                                  write_data);
    assign read_b_data = read_reg(read_b_num, regs[read_b_num], write_live, write_num,
                                  write_data);

endmodule

/* src/core_alu.sv */
`timescale 1ns/100ps

module core_alu (
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    input  core_pkg::alu_op_t         alu_op,
    output logic [core_pkg::xlen-1:0] out,
    output logic                      overflow,
    output logic                      zero,
    output logic                      negative
);
    import core_pkg::*;

    logic            is_sub;
    logic [xlen-1:0] b_eff;
    logic [xlen-1:0] sum;

    // Subtract as a + ~b + 1.
    assign is_sub = (alu_op == alu_sub);
    assign b_eff  = is_sub ? ~b : b;
    assign sum    = a + b_eff + {{(xlen - 1){1'b0}}, is_sub};

    always_comb begin
        case (alu_op)
            alu_and: out = a & b;
            alu_or:  out = a | b;
            alu_xor: out = a ^ b;
            alu_nor: out = ~(a | b);
            default: out = sum;
        endcase
    end

    // Operands agree in sign but the sum does not.
    assign overflow = ((alu_op == alu_add) || is_sub)
                      && (a[xlen-1] == b_eff[xlen-1])
                      && (sum[xlen-1] != a[xlen-1]);

    assign zero     = (out == '0);
    assign negative = out[xlen-1];

endmodule

/* src/core_decode.sv */
`timescale 1ns/100ps

module core_decode #(
    parameter int num_regs = 32
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    output core_pkg::regnum_t         read_a_num,
    output core_pkg::regnum_t         read_b_num,
    input  logic [core_pkg::xlen-1:0] read_a_data,
    input  logic [core_pkg::xlen-1:0] read_b_data,
    stage_if.producer                 id
);
    import core_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regnum_t    rs;
    regnum_t    rt;
    regnum_t    rd;
    logic       known;
    logic       fits;
    id_regs_t   next;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    assign read_a_num = rs;
    assign read_b_num = rt;

    // Register numbers beyond the file size are treated as unknown.
    assign fits = (int'(rs) < num_regs) && (int'(rt) < num_regs) && (int'(rd) < num_regs);

    always_comb begin
        next        = '0;
        next.instr  = instr;
        next.a_data = read_a_data;
        next.b_data = read_b_data;
        known       = 1'b1;
        if (opcode == op_special) begin
            next.w_regnum = rd;
            case (funct)
                fn_add:    next.cut_alu_out32 = 1'b1;
                fn_sub: begin
                    next.alu_op        = alu_sub;
                    next.cut_alu_out32 = 1'b1;
                end
                fn_and:    next.alu_op = alu_and;
                fn_or:     next.alu_op = alu_or;
                fn_xor:    next.alu_op = alu_xor;
                fn_nor:    next.alu_op = alu_nor;
                fn_slt: begin
                    next.alu_op = alu_sub;
                    next.slt    = 1'b1;
                end
                fn_dadd:   next.alu_op = alu_add;
                fn_dsub:   next.alu_op = alu_sub;
                fn_sll: begin
                    next.alu_shifter_src   = 1'b1;
                    next.cut_shifter_out32 = 1'b1;
                end
                fn_srl: begin
                    next.alu_shifter_src   = 1'b1;
                    next.cut_shifter_out32 = 1'b1;
                    next.shift_right       = 1'b1;
                end
                fn_dsll:   next.alu_shifter_src = 1'b1;
                fn_dsrl: begin
                    next.alu_shifter_src = 1'b1;
                    next.shift_right     = 1'b1;
                end
                fn_dsll32: begin
                    next.alu_shifter_src = 1'b1;
                    next.shifter_plus32  = plus32_left;
                end
                fn_dsrl32: begin
                    next.alu_shifter_src = 1'b1;
                    next.shift_right     = 1'b1;
                    next.shifter_plus32  = plus32_right;
                end
                default:   known = 1'b0;
            endcase
        end else begin
            next.w_regnum = rt;
            next.imm_src  = sign_imm;
            case (opcode)
                op_addi:  next.cut_alu_out32 = 1'b1;
                op_daddi: next.alu_op = alu_add;
                op_andi: begin
                    next.alu_op  = alu_and;
                    next.imm_src = zero_imm;
                end
                op_ori: begin
                    next.alu_op  = alu_or;
                    next.imm_src = zero_imm;
                end
                op_slti: begin
                    next.alu_op = alu_sub;
                    next.slt    = 1'b1;
                end
                op_lui:   next.lui = 1'b1;
                default:  known = 1'b0;
            endcase
        end
        // Bubbles and unknown encodings travel as an all-zero payload.
        if (instr_valid && known && fits) begin
            next.valid        = 1'b1;
            next.write_enable = 1'b1;
        end else begin
            next = '0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            id.regs <= '0;
        end else if (id.flush) begin
            id.regs <= '0;
        end else begin
            id.regs <= next;
        end
    end

    assign id.valid = id.regs.valid;

endmodule

/* src/core_forward.sv */
`timescale 1ns/100ps

module core_forward #(
    parameter int num_regs = 32
) (
    stage_if.consumer          id,
    stage_if.consumer          ex,
    input  core_pkg::regnum_t  mem_regnum,
    input  logic               mem_write_enable,
    output core_pkg::forward_t forward_a,
    output core_pkg::forward_t forward_b
);
    import core_pkg::*;

    regnum_t rs;
    regnum_t rt;
    logic    ex_live;

    assign rs      = id.regs.instr[25:21];
    assign rt      = id.regs.instr[20:16];
    assign ex_live = !ex.clear && ex.regs.write_enable;

    // The newer producer wins. Register zero always comes from the file.
    function automatic forward_t pick(input regnum_t src,
                                      input logic ex_we, input regnum_t ex_num,
                                      input logic mem_we, input regnum_t mem_num);
        if ((src == '0) || (int'(src) >= num_regs)) begin
            return from_reg;
        end
        if (ex_we && (ex_num == src)) begin
            return from_ex;
        end
        if (mem_we && (mem_num == src)) begin
            return from_mem;
        end
        return from_reg;
    endfunction

    assign forward_a = pick(rs, ex_live, ex.regs.w_regnum, mem_write_enable, mem_regnum);
    assign forward_b = pick(rt, ex_live, ex.regs.w_regnum, mem_write_enable, mem_regnum);

endmodule

/* src/core_execute.sv */
`timescale 1ns/100ps

module core_execute (
    input  logic                      clock,
    input  logic                      reset,
    stage_if.consumer                 id,
    input  logic [core_pkg::xlen-1:0] mem_data,
    input  core_pkg::forward_t        forward_a,
    input  core_pkg::forward_t        forward_b,
    stage_if.producer                 ex
);
    import core_pkg::*;

    logic [xlen-1:0] a_fwd;
    logic [xlen-1:0] b_fwd;
    logic [xlen-1:0] b_in;
    logic [xlen-1:0] sign_ext_imm;
    logic [xlen-1:0] zero_ext_imm;
    logic [xlen-1:0] alu_raw;
    logic [xlen-1:0] alu_cut;
    logic [xlen-1:0] shift_in;
    logic [xlen-1:0] shift_raw;
    logic [xlen-1:0] shift_cut;
    logic [xlen-1:0] shift_out;
    logic [xlen-1:0] result;
    logic [4:0]      shamt;
    logic            alu_ovf;
    logic            alu_neg;
    logic            slt_bit;
    logic            overflow;

    // ==========================================================================
    // Operand selection.
    // ==========================================================================

    always_comb begin
        case (forward_a)
            from_ex:  a_fwd = ex.regs.out;
            from_mem: a_fwd = mem_data;
            default:  a_fwd = id.regs.a_data;
        endcase
        case (forward_b)
            from_ex:  b_fwd = ex.regs.out;
            from_mem: b_fwd = mem_data;
            default:  b_fwd = id.regs.b_data;
        endcase
    end

    assign sign_ext_imm = {{(xlen - 16){id.regs.instr[15]}}, id.regs.instr[15:0]};
    assign zero_ext_imm = {{(xlen - 16){1'b0}}, id.regs.instr[15:0]};

    always_comb begin
        case (id.regs.imm_src)
            sign_imm: b_in = sign_ext_imm;
            zero_imm: b_in = zero_ext_imm;
            default:  b_in = b_fwd;
        endcase
    end

    // ==========================================================================
    // ALU and shifter.
    // ==========================================================================

    core_alu i_alu (
        .a        (a_fwd),
        .b        (b_in),
        .alu_op   (id.regs.alu_op),
        .out      (alu_raw),
        .overflow (alu_ovf),
        .zero     (),
        .negative (alu_neg)
    );

    assign alu_cut = id.regs.cut_alu_out32 ? {{(xlen - 32){alu_raw[31]}}, alu_raw[31:0]}
                                           : alu_raw;

    // Word shifts work on the low word only.
    assign shamt     = id.regs.instr[10:6];
    assign shift_in  = id.regs.cut_shifter_out32 ? {{(xlen - 32){1'b0}}, b_fwd[31:0]} : b_fwd;
    assign shift_raw = id.regs.shift_right ? (shift_in >> shamt) : (shift_in << shamt);
    assign shift_cut = id.regs.cut_shifter_out32
                       ? {{(xlen - 32){shift_raw[31]}}, shift_raw[31:0]} : shift_raw;

    always_comb begin
        case (id.regs.shifter_plus32)
            plus32_left:  shift_out = {shift_cut[31:0], 32'b0};
            plus32_right: shift_out = {32'b0, shift_cut[xlen-1:32]};
            default:      shift_out = shift_cut;
        endcase
    end

    // Mixed signs decide directly, otherwise the sign of a - b.
    assign slt_bit = (a_fwd[xlen-1] & ~b_in[xlen-1])
                     | ((a_fwd[xlen-1] == b_in[xlen-1]) & alu_neg);

    always_comb begin
        if (id.regs.lui) begin
            result = {sign_ext_imm[xlen-17:0], 16'b0};
        end else if (id.regs.slt) begin
            result = {{(xlen - 1){1'b0}}, slt_bit};
        end else if (id.regs.alu_shifter_src) begin
            result = shift_out;
        end else begin
            result = alu_cut;
        end
    end

    // Word ops overflow when bits 32 and 31 of the wide sum disagree.
    assign overflow = !(id.regs.lui || id.regs.slt || id.regs.alu_shifter_src)
                      && (id.regs.cut_alu_out32 ? (alu_raw[32] ^ alu_raw[31]) : alu_ovf);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ex.regs <= '0;
        end else if (ex.flush) begin
            ex.regs <= '0;
        end else begin
            ex.regs.valid        <= id.regs.valid;
            ex.regs.out          <= result;
            ex.regs.w_regnum     <= id.regs.w_regnum;
            ex.regs.write_enable <= id.regs.write_enable;
            ex.regs.overflow     <= overflow;
        end
    end

    assign ex.valid = ex.regs.valid;

endmodule

/* src/core_result.sv */
`timescale 1ns/100ps

module core_result (
    input  logic                      clock,
    input  logic                      reset,
    stage_if.consumer                 ex,
    output logic [core_pkg::xlen-1:0] mem_data,
    output core_pkg::regnum_t         mem_regnum,
    output logic                      mem_write_enable,
    output logic                      write_enable,
    output core_pkg::regnum_t         write_num,
    output logic [core_pkg::xlen-1:0] write_data,
    output logic                      result_valid,
    output core_pkg::regnum_t         result_regnum,
    output logic [core_pkg::xlen-1:0] result_data,
    output logic                      result_overflow
);
    import core_pkg::*;

    ex_regs_t res;
    logic     writes;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            res <= '0;
        end else begin
            res <= ex.regs;
        end
    end

    assign writes = res.valid & res.write_enable;

    // One register feeds forwarding, the file write and the report.
    assign mem_data         = res.out;
    assign mem_regnum       = res.w_regnum;
    assign mem_write_enable = writes;

    assign write_enable = writes;
    assign write_num    = res.w_regnum;
    assign write_data   = res.out;

    assign result_valid    = writes;
    assign result_regnum   = res.w_regnum;
    assign result_data     = res.out;
    assign result_overflow = res.overflow;

endmodule

/* src/core_top.sv */
`timescale 1ns/100ps

module core_top #(
    parameter int num_regs = 32
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic                      flush,
    output logic                      result_valid,
    output core_pkg::regnum_t         result_regnum,
    output logic [core_pkg::xlen-1:0] result_data,
    output logic                      result_overflow
);
    import core_pkg::*;

    regnum_t         read_a_num;
    regnum_t         read_b_num;
    logic [xlen-1:0] read_a_data;
    logic [xlen-1:0] read_b_data;
    logic            rf_write_enable;
    regnum_t         rf_write_num;
    logic [xlen-1:0] rf_write_data;
    logic [xlen-1:0] mem_data;
    regnum_t         mem_regnum;
    logic            mem_write_enable;
    forward_t        forward_a;
    forward_t        forward_b;

    stage_if #(.payload_t(id_regs_t)) id_if (.flush(flush));
    stage_if #(.payload_t(ex_regs_t)) ex_if (.flush(flush));

    core_regfile #(.num_regs(num_regs)) i_regfile (
        .clock        (clock),
        .reset        (reset),
        .read_a_num   (read_a_num),
        .read_b_num   (read_b_num),
        .read_a_data  (read_a_data),
        .read_b_data  (read_b_data),
        .write_enable (rf_write_enable),
        .write_num    (rf_write_num),
        .write_data   (rf_write_data)
    );

    core_decode #(.num_regs(num_regs)) i_decode (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .read_a_num  (read_a_num),
        .read_b_num  (read_b_num),
        .read_a_data (read_a_data),
        .read_b_data (read_b_data),
        .id          (id_if.producer)
    );

    core_forward #(.num_regs(num_regs)) i_forward (
        .id               (id_if.consumer),
        .ex               (ex_if.consumer),
        .mem_regnum       (mem_regnum),
        .mem_write_enable (mem_write_enable),
        .forward_a        (forward_a),
        .forward_b        (forward_b)
    );

    core_execute i_execute (
        .clock     (clock),
        .reset     (reset),
        .id        (id_if.consumer),
        .mem_data  (mem_data),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .ex        (ex_if.producer)
    );

    core_result i_result (
        .clock            (clock),
        .reset            (reset),
        .ex               (ex_if.consumer),
        .mem_data         (mem_data),
        .mem_regnum       (mem_regnum),
        .mem_write_enable (mem_write_enable),
        .write_enable     (rf_write_enable),
        .write_num        (rf_write_num),
        .write_data       (rf_write_data),
        .result_valid     (result_valid),
        .result_regnum    (result_regnum),
        .result_data      (result_data),
        .result_overflow  (result_overflow)
    );

endmodule

/* test/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
    import core_pkg::*;

    localparam int reset_cycles = 2;
    localparam int latency      = 3;

    typedef struct packed {
        logic [31:0]     instr;
        logic            instr_valid;
        logic            flush;
        logic            exp_valid;
        regnum_t         exp_regnum;
        logic [xlen-1:0] exp_data;
        logic            exp_overflow;
    } step_t;

    logic            clock;
    logic            reset;
    logic            instr_valid;
    logic [31:0]     instr;
    logic            flush;
    logic            result_valid;
    regnum_t         result_regnum;
    logic [xlen-1:0] result_data;
    logic            result_overflow;

    step_t steps [$];
    int    cycles = 0;

    core_top #(.num_regs(32)) i_dut (
        .clock           (clock),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .flush           (flush),
        .result_valid    (result_valid),
        .result_regnum   (result_regnum),
        .result_data     (result_data),
        .result_overflow (result_overflow)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // ==========================================================================
    // Instruction encoding and table rows.
    // ==========================================================================

    function automatic logic [31:0] r_word(input logic [5:0] funct, input regnum_t rs,
                                           input regnum_t rt, input regnum_t rd,
                                           input logic [4:0] shamt);
        return {op_special, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] opcode, input regnum_t rs,
                                           input regnum_t rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    task automatic writes_reg(input logic [31:0] word, input regnum_t num,
                              input logic [xlen-1:0] data, input logic ovf);
        step_t s;
        s              = '0;
        s.instr        = word;
        s.instr_valid  = 1'b1;
        s.exp_valid    = 1'b1;
        s.exp_regnum   = num;
        s.exp_data     = data;
        s.exp_overflow = ovf;
        steps.push_back(s);
    endtask

    task automatic no_result(input logic [31:0] word, input logic valid, input logic flush_in);
        step_t s;
        s             = '0;
        s.instr       = word;
        s.instr_valid = valid;
        s.flush       = flush_in;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // Immediates and extension.
        writes_reg(i_word(op_ori, 0, 1, 16'h8001), 1, 64'h0000_0000_0000_8001, 0);
        writes_reg(i_word(op_addi, 0, 2, 16'h8000), 2, 64'hffff_ffff_ffff_8000, 0);
        writes_reg(i_word(op_lui, 0, 3, 16'h8000), 3, 64'hffff_ffff_8000_0000, 0);
        writes_reg(i_word(op_lui, 0, 4, 16'h1234), 4, 64'h0000_0000_1234_0000, 0);
        // Dependent chain at distances one to three.
        writes_reg(r_word(fn_add, 4, 1, 5, 0), 5, 64'h0000_0000_1234_8001, 0);
        writes_reg(r_word(fn_sub, 5, 4, 6, 0), 6, 64'h0000_0000_0000_8001, 0);
        writes_reg(r_word(fn_or, 4, 6, 7, 0), 7, 64'h0000_0000_1234_8001, 0);
        writes_reg(r_word(fn_and, 7, 2, 8, 0), 8, 64'h0000_0000_1234_8000, 0);
        writes_reg(r_word(fn_xor, 6, 8, 9, 0), 9, 64'h0000_0000_1234_0001, 0);
        writes_reg(r_word(fn_nor, 9, 7, 10, 0), 10, 64'hffff_ffff_edcb_7ffe, 0);
        // Both stages hold r9, the newer one wins.
        writes_reg(i_word(op_addi, 0, 9, 16'h0005), 9, 64'h5, 0);
        writes_reg(i_word(op_addi, 9, 9, 16'h0001), 9, 64'h6, 0);
        writes_reg(r_word(fn_add, 9, 9, 11, 0), 11, 64'hc, 0);
        writes_reg(i_word(op_ori, 0, 0, 16'hffff), 0, 64'h0000_0000_0000_ffff, 0);
        writes_reg(r_word(fn_add, 0, 11, 12, 0), 12, 64'hc, 0);
        // Set-less-than.
        writes_reg(r_word(fn_slt, 3, 1, 13, 0), 13, 64'h1, 0);
        writes_reg(r_word(fn_slt, 1, 3, 14, 0), 14, 64'h0, 0);
        writes_reg(r_word(fn_slt, 1, 11, 15, 0), 15, 64'h0, 0);
        writes_reg(i_word(op_slti, 11, 16, 16'h7fff), 16, 64'h1, 0);
        writes_reg(i_word(op_slti, 2, 17, 16'hffff), 17, 64'h1, 0);
        writes_reg(i_word(op_slti, 11, 18, 16'h8000), 18, 64'h0, 0);
        // Shifts.
        writes_reg(r_word(fn_sll, 0, 7, 19, 3), 19, 64'hffff_ffff_91a4_0008, 0);
        writes_reg(r_word(fn_srl, 0, 3, 20, 4), 20, 64'h0000_0000_0800_0000, 0);
        writes_reg(r_word(fn_dsll, 0, 4, 21, 8), 21, 64'h0000_0012_3400_0000, 0);
        writes_reg(r_word(fn_dsrl, 0, 3, 22, 4), 22, 64'h0fff_ffff_f800_0000, 0);
        writes_reg(r_word(fn_dsll32, 0, 1, 23, 4), 23, 64'h0008_0010_0000_0000, 0);
        writes_reg(r_word(fn_dsrl32, 0, 3, 24, 4), 24, 64'h0000_0000_0fff_ffff, 0);
        // Overflow.
        writes_reg(i_word(op_lui, 0, 25, 16'h7fff), 25, 64'h0000_0000_7fff_0000, 0);
        writes_reg(r_word(fn_add, 25, 25, 26, 0), 26, 64'hffff_ffff_fffe_0000, 1);
        writes_reg(r_word(fn_dadd, 25, 25, 27, 0), 27, 64'h0000_0000_fffe_0000, 0);
        writes_reg(r_word(fn_dsub, 27, 25, 28, 0), 28, 64'h0000_0000_7fff_0000, 0);
        // Bubble, unknown encodings, then a flush that drops two instructions.
        no_result(i_word(op_addi, 0, 1, 16'h0055), 0, 0);
        no_result(i_word(6'h3f, 1, 2, 16'h1234), 1, 0);
        no_result(r_word(6'h01, 1, 2, 3, 0), 1, 0);
        writes_reg(i_word(op_addi, 0, 29, 16'h0007), 29, 64'h7, 0);
        no_result(i_word(op_addi, 0, 30, 16'h0008), 1, 0);
        no_result(i_word(op_addi, 0, 31, 16'h0009), 1, 1);
        writes_reg(r_word(fn_add, 30, 31, 1, 0), 1, 64'h0, 0);
        writes_reg(r_word(fn_add, 29, 29, 2, 0), 2, 64'he, 0);
        // Drain.
        repeat (latency) no_result(32'h0, 0, 0);
    endtask

    // ==========================================================================
    // Checking.
    // ==========================================================================

    task automatic check_value(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Stopping at the first wrong value.");
        end
    endtask

    task automatic verify_write_back(input step_t want, input int row);
        check_value(64'(result_valid), 64'(want.exp_valid),
                    $sformatf("result_valid for row %0d", row));
        if (want.exp_valid) begin
            check_value(64'(result_regnum), 64'(want.exp_regnum),
                        $sformatf("result_regnum for row %0d", row));
            check_value(result_data, want.exp_data, $sformatf("result_data for row %0d", row));
            check_value(64'(result_overflow), 64'(want.exp_overflow),
                        $sformatf("result_overflow for row %0d", row));
        end
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > steps.size() + reset_cycles + 10) begin
            $display("Timeout: the run went on for %0d cycles without finishing", cycles);
            $display("Simulation failed");
            $fatal(1, "Stopping on timeout.");
        end
    end

    initial begin
        step_t want;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        flush       = 1'b0;
        build_table();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clock);
            instr       <= steps[i].instr;
            instr_valid <= steps[i].instr_valid;
            flush       <= steps[i].flush;
            // Outputs are settled by the falling edge.
            @(negedge clock);
            if (i < latency) begin
                check_value(64'(result_valid), 64'd0,
                            $sformatf("result_valid after reset, step %0d", i));
            end else begin
                want = steps[i - latency];
                verify_write_back(want, i - latency);
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* src.f */
src/core_pkg.sv
src/stage_if.sv
src/core_regfile.sv
src/core_alu.sv
src/core_decode.sv
src/core_forward.sv
src/core_execute.sv
src/core_result.sv
src/core_top.sv
test/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
